/* refill_pkg.sv */
`default_nettype none

package refill_pkg;

    // line geometry
    localparam int WORDS_PER_LINE   = 4;
    localparam int LINE_OFFSET_BITS = 4;

    // axi encodings used by the read engine
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // word 0 sits in the lowest bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // one returned line, 161 bits
    typedef struct packed {
        addr_t addr;
        line_t data;
        logic  err;
    } refill_rsp_t;

    // read address channel payload
    typedef struct packed {
        logic [3:0] arid;
        addr_t      araddr;
        logic [7:0] arlen;
        logic [2:0] arsize;
        logic [1:0] arburst;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [3:0] rid;
        word_t      rdata;
        logic [1:0] rresp;
        logic       rlast;
    } axi_r_t;

endpackage

`default_nettype wire

/* line_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module line_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  wire logic aclk,
    input  wire logic rst,
    input  wire logic push,
    input  wire T     push_data,
    output logic      full,
    input  wire logic pop,
    output T          pop_data,
    output logic      empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // guard against protocol slips at either side
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry always on the read side
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* cache_side_port.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_side_port
    import refill_pkg::*;
(
    input  wire logic        aclk,
    input  wire logic        rst,

    // miss handshake from the cache
    input  wire logic        miss_req,
    input  wire addr_t       miss_addr,
    output logic             miss_ack,

    // miss queue write side
    output logic             miss_push,
    output addr_t            miss_line_addr,
    input  wire logic        miss_full,

    // refill handshake to the cache
    output logic             refill_req,
    output refill_rsp_t      refill,
    input  wire logic        refill_ack,

    // line queue read side
    output logic             line_pop,
    input  wire refill_rsp_t line_head,
    input  wire logic        line_empty
);

    typedef enum logic {
        M_IDLE,
        M_ACK
    } miss_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_RELEASE
    } refill_state_t;

    miss_state_t   miss_state;
    refill_state_t refill_state;
    refill_rsp_t   refill_q;

    // drop the offset bits so the queue only holds line addresses
    assign miss_line_addr = {miss_addr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    assign miss_push = (miss_state == M_IDLE) && miss_req && !miss_full;
    assign miss_ack  = (miss_state == M_ACK);

    // receive side holds ack until req has gone low
    always_ff @(posedge aclk) begin
        if (rst) begin
            miss_state <= M_IDLE;
        end else begin
            case (miss_state)
                M_IDLE: begin
                    if (miss_push) begin
                        miss_state <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (!miss_req) begin
                        miss_state <= M_IDLE;
                    end
                end
                default: miss_state <= M_IDLE;
            endcase
        end
    end

    assign line_pop   = (refill_state == R_IDLE) && !line_empty;
    assign refill_req = (refill_state == R_REQ);
    assign refill     = refill_q;

    // popped line held stable for the whole handshake
    always_ff @(posedge aclk) begin
        if (line_pop) begin
            refill_q <= line_head;
        end
    end

    // send side
    always_ff @(posedge aclk) begin
        if (rst) begin
            refill_state <= R_IDLE;
        end else begin
            case (refill_state)
                R_IDLE: begin
                    if (line_pop) begin
                        refill_state <= R_REQ;
                    end
                end
                R_REQ: begin
                    if (refill_ack) begin
                        refill_state <= R_RELEASE;
                    end
                end
                R_RELEASE: begin
                    // wait for the cache to let go of ack
                    if (!refill_ack) begin
                        refill_state <= R_IDLE;
                    end
                end
                default: refill_state <= R_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* axi_read_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_read_engine
    import refill_pkg::*;
#(
    parameter logic [3:0] AXI_ID = 4'h1
) (
    input  wire logic   aclk,
    input  wire logic   rst,

    // miss queue read side
    output logic        miss_pop,
    input  wire addr_t  miss_head,
    input  wire logic   miss_empty,

    // line queue write side
    output logic        line_push,
    output refill_rsp_t line_out,
    input  wire logic   line_full,

    // axi read address channel
    output axi_ar_t     ar,
    output logic        arvalid,
    input  wire logic   arready,

    // axi read data channel
    input  wire axi_r_t r,
    input  wire logic   rvalid,
    output logic        rready
);

    localparam int BEAT_W = $clog2(WORDS_PER_LINE);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_BEATS,
        S_PUSH
    } state_t;

    state_t state;

    logic [BEAT_W-1:0] beat_cnt;
    addr_t             addr_q;
    line_t             line_q;
    logic              err_q;

    logic              ar_done;
    logic              beat_done;

    assign ar_done   = arvalid && arready;
    assign beat_done = rvalid && rready;

    // only take a new miss once the previous line has left
    assign miss_pop  = (state == S_IDLE) && !miss_empty;
    assign arvalid   = (state == S_ADDR);
    assign rready    = (state == S_BEATS);
    assign line_push = (state == S_PUSH) && !line_full;

    // fixed burst shape of one full line per request
    assign ar.arid    = AXI_ID;
    assign ar.araddr  = addr_q;
    assign ar.arlen   = 8'(WORDS_PER_LINE - 1);
    assign ar.arsize  = AXI_SIZE_WORD;
    assign ar.arburst = AXI_BURST_INCR;

    assign line_out.addr = addr_q;
    assign line_out.data = line_q;
    assign line_out.err  = err_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss_pop) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (ar_done) begin
                        state    <= S_BEATS;
                        beat_cnt <= '0;
                    end
                end
                S_BEATS: begin
                    if (beat_done) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.rlast) begin
                            state <= S_PUSH;
                        end
                    end
                end
                S_PUSH: begin
                    // hold the line while the queue is full
                    if (line_push) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // line payload
    always_ff @(posedge aclk) begin
        if (miss_pop) begin
            addr_q <= miss_head;
        end
        if (ar_done) begin
            err_q <= 1'b0;
        end
        if (beat_done) begin
            line_q[beat_cnt] <= r.rdata;
            // sticky over the burst
            if (r.rresp != AXI_RESP_OKAY) begin
                err_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* line_refill_top.sv */
`timescale 1ns/1ns
`default_nettype none

module line_refill_top
    import refill_pkg::*;
#(
    parameter int         MISS_DEPTH = 4,
    parameter int         LINE_DEPTH = 2,
    parameter logic [3:0] AXI_ID     = 4'h1
) (
    input  wire logic   aclk,
    input  wire logic   rst,

    // cache side
    input  wire logic   miss_req,
    input  wire addr_t  miss_addr,
    output logic        miss_ack,
    output logic        refill_req,
    output refill_rsp_t refill,
    input  wire logic   refill_ack,

    // axi read side
    output axi_ar_t     ar,
    output logic        arvalid,
    input  wire logic   arready,
    input  wire axi_r_t r,
    input  wire logic   rvalid,
    output logic        rready
);

    // miss queue
    logic        miss_push;
    addr_t       miss_line_addr;
    logic        miss_full;
    logic        miss_pop;
    addr_t       miss_head;
    logic        miss_empty;

    // line queue
    logic        line_push;
    refill_rsp_t line_out;
    logic        line_full;
    logic        line_pop;
    refill_rsp_t line_head;
    logic        line_empty;

    line_fifo #(
        .T     (addr_t),
        .DEPTH (MISS_DEPTH)
    ) miss_queue (
        .aclk      (aclk),
        .rst       (rst),
        .push      (miss_push),
        .push_data (miss_line_addr),
        .full      (miss_full),
        .pop       (miss_pop),
        .pop_data  (miss_head),
        .empty     (miss_empty)
    );

    line_fifo #(
        .T     (refill_rsp_t),
        .DEPTH (LINE_DEPTH)
    ) line_queue (
        .aclk      (aclk),
        .rst       (rst),
        .push      (line_push),
        .push_data (line_out),
        .full      (line_full),
        .pop       (line_pop),
        .pop_data  (line_head),
        .empty     (line_empty)
    );

    cache_side_port i_cache_side_port (
        .aclk           (aclk),
        .rst            (rst),
        .miss_req       (miss_req),
        .miss_addr      (miss_addr),
        .miss_ack       (miss_ack),
        .miss_push      (miss_push),
        .miss_line_addr (miss_line_addr),
        .miss_full      (miss_full),
        .refill_req     (refill_req),
        .refill         (refill),
        .refill_ack     (refill_ack),
        .line_pop       (line_pop),
        .line_head      (line_head),
        .line_empty     (line_empty)
    );

    axi_read_engine #(
        .AXI_ID (AXI_ID)
    ) i_axi_read_engine (
        .aclk       (aclk),
        .rst        (rst),
        .miss_pop   (miss_pop),
        .miss_head  (miss_head),
        .miss_empty (miss_empty),
        .line_push  (line_push),
        .line_out   (line_out),
        .line_full  (line_full),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem
    import refill_pkg::*;
(
    input  wire logic    aclk,
    input  wire logic    rst,
    input  wire logic    stall_en,
    input  wire axi_ar_t ar,
    input  wire logic    arvalid,
    output logic         arready,
    output axi_r_t       r,
    output logic         rvalid,
    input  wire logic    rready,
    output int           ar_errors
);

    // line addresses in the order the misses were sent
    addr_t exp_ar_q[$];

    task automatic expect_ar(input addr_t line_addr);
        exp_ar_q.push_back(line_addr);
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
        if (got !== exp) begin
            ar_errors = ar_errors + 1;
            $display("ERR %0t: ar got id %h addr %h len %h size %h burst %h, exp %h %h %h %h %h",
                     $time, got.arid, got.araddr, got.arlen, got.arsize, got.arburst,
                     exp.arid, exp.araddr, exp.arlen, exp.arsize, exp.arburst);
        end
    endtask

    initial begin : responder
        axi_ar_t exp;
        addr_t   line_addr;
        logic    [3:0] rid_q;
        logic    busy;
        int      beat;
        arready   = 1'b0;
        rvalid    = 1'b0;
        r         = '0;
        ar_errors = 0;
        busy      = 1'b0;
        beat      = 0;
        line_addr = '0;
        rid_q     = '0;
        forever begin
            @(posedge aclk);
            if (rst) begin
                arready <= 1'b0;
                rvalid  <= 1'b0;
                busy    = 1'b0;
            end else if (!busy) begin
                if (arvalid && arready) begin
                    if (exp_ar_q.size() == 0) begin
                        $display("unexpected ar transfer at %0t with no miss outstanding", $time);
                        ar_errors = ar_errors + 1;
                    end else begin
                        exp.arid    = 4'h1;
                        exp.araddr  = exp_ar_q.pop_front();
                        exp.arlen   = 8'd3;
                        exp.arsize  = 3'b010;
                        exp.arburst = 2'b01;
                        check_ar(ar, exp);
                    end
                    line_addr = ar.araddr;
                    rid_q     = ar.arid;
                    busy      = 1'b1;
                    beat      = 0;
                    arready <= 1'b0;
                end else begin
                    arready <= !stall_en || ($urandom_range(3, 0) != 0);
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
                if (r.rlast) begin
                    busy = 1'b0;
                end else begin
                    beat = beat + 1;
                end
            end else if (!rvalid && (!stall_en || $urandom_range(2, 0) != 0)) begin
                // word at byte address a is a xor c0de0000
                r.rid   <= rid_q;
                r.rdata <= (line_addr + 32'(beat * 4)) ^ 32'hc0de_0000;
                // slverr on beat 2 when bit 20 of the line is set
                r.rresp <= (line_addr[20] && beat == 2) ? 2'b10 : 2'b00;
                r.rlast <= (beat == 3);
                rvalid  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_line_refill.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_line_refill
    import refill_pkg::*;
();

    localparam int NUM_RANDOM = 30;
    localparam int NUM_MISSES = 1 + 2 * NUM_RANDOM + 2;

    logic        aclk;
    logic        rst;
    logic        miss_req;
    addr_t       miss_addr;
    logic        miss_ack;
    logic        refill_req;
    refill_rsp_t refill;
    logic        refill_ack;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    logic        stall_en;
    int          ar_errors;

    refill_rsp_t exp_q[$];
    addr_t       rand_addrs[NUM_RANDOM];
    int          errors = 0;
    int          checks = 0;
    int          sent_count = 0;
    int          done_count = 0;
    int          max_ack_delay = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    line_refill_top #(
        .MISS_DEPTH (4),
        .LINE_DEPTH (2),
        .AXI_ID     (4'h1)
    ) i_line_refill_top (.*);

    tb_axi_mem i_mem (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // aligned line address, address-xor data per word, err when bit 20 is set
    function automatic refill_rsp_t expected_refill(input addr_t miss);
        refill_rsp_t exp;
        addr_t       line_addr;
        line_addr = miss & 32'hffff_fff0;
        exp.addr  = line_addr;
        for (int i = 0; i < 4; i++) begin
            exp.data[i] = (line_addr + 32'(i * 4)) ^ 32'hc0de_0000;
        end
        exp.err = line_addr[20];
        return exp;
    endfunction

    task automatic check_refill(input refill_rsp_t got, input refill_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: refill got addr %h data %h err %b, expected addr %h data %h err %b",
                     $time, got.addr, got.data, got.err, exp.addr, exp.data, exp.err);
        end
    endtask

    task automatic check_low(input logic got, input string name);
        if (got !== 1'b0) begin
            errors++;
            $display("ERR %0t: %s is %b after reset, expected 0", $time, name, got);
        end
    endtask

    task automatic send_miss(input addr_t a);
        exp_q.push_back(expected_refill(a));
        i_mem.expect_ar(a & 32'hffff_fff0);
        sent_count++;
        miss_req  <= 1'b1;
        miss_addr <= a;
        do @(posedge aclk); while (!miss_ack);
        miss_req <= 1'b0;
        do @(posedge aclk); while (miss_ack);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        while (done_count < sent_count) @(posedge aclk);
        errs = errors + ar_errors - errs_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "pass" : "fail");
    endtask

    // takes each refill in order, compares it, then acks after a random delay
    initial begin : refill_compare
        int delay;
        refill_ack = 1'b0;
        forever begin
            @(posedge aclk);
            if (refill_req && !refill_ack) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("refill arrived at %0t with no miss outstanding", $time);
                end else begin
                    check_refill(refill, exp_q.pop_front());
                end
                delay = $urandom_range(max_ack_delay, 0);
                repeat (delay) @(posedge aclk);
                refill_ack <= 1'b1;
                do @(posedge aclk); while (refill_req);
                refill_ack <= 1'b0;
                done_count++;
            end
        end
    end

    initial begin : stimulus
        int base;
        void'($urandom(32'he12));
        rst       = 1'b1;
        miss_req  = 1'b0;
        miss_addr = '0;
        stall_en  = 1'b0;
        repeat (5) @(posedge aclk);
        rst <= 1'b0;

        base = errors + ar_errors;
        repeat (10) begin
            @(posedge aclk);
            check_low(miss_ack, "miss_ack");
            check_low(refill_req, "refill_req");
            check_low(arvalid, "arvalid");
            check_low(rready, "rready");
        end
        finish_test("idle after reset", base);

        base = errors + ar_errors;
        send_miss(32'h0000_1237);
        finish_test("single unaligned miss", base);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_addrs[i] = $urandom();
        end
        base          = errors + ar_errors;
        max_ack_delay = 6;
        foreach (rand_addrs[i]) begin
            send_miss(rand_addrs[i]);
        end
        finish_test("random misses in order", base);

        // same addresses again under axi stalls
        base = errors + ar_errors;
        stall_en <= 1'b1;
        foreach (rand_addrs[i]) begin
            send_miss(rand_addrs[i]);
        end
        finish_test("random misses with axi stalls", base);

        base = errors + ar_errors;
        send_miss(32'h0010_2348);
        send_miss(32'h0000_2358);
        finish_test("error region then clean line", base);

        $display("%0d tests, %0d failed, %0d refill checks, %0d errors",
                 tests_run, tests_failed, checks, errors + ar_errors);
        if (errors + ar_errors == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_MISSES * 200) @(posedge aclk);
        $display("run timed out after %0d cycles with refills still missing", NUM_MISSES * 200);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* line_refill.f */
refill_pkg.sv
line_fifo.sv
cache_side_port.sv
axi_read_engine.sv
line_refill_top.sv
tb_axi_mem.sv
tb_line_refill.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_line_refill
FILELIST = line_refill.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only when the pass line shows up in the output
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(BUILD)
